// File: compile.f
+incdir+design
design/riscv_isa_pkg.sv
design/core_ctrl_pkg.sv
design/decoder.sv
design/register_file.sv
design/alu.sv
design/fetch_unit.sv
design/core.sv
verification/core_chk.sv
verification/tb_core.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core -f compile.f -o sim_core \
    || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/sim_core 2>&1)
echo "$sim_out"

echo "$sim_out" | grep -qx "NO ERRORS" && exit 0 || { echo "simulation failed"; exit 1; }

// File: verification/tb_core.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module tb_core;
    import riscv_isa_pkg::*;

    typedef logic [`DMEM_ADDR_W-1:0] daddr_t;

    localparam int ROM_DEPTH  = 64;
    localparam int DMEM_DEPTH = 2 ** `DMEM_ADDR_W;
    localparam int MAX_STORES = 32;
    localparam int WAIT_LIMIT = 100;

    logic   clk;
    logic   rst_n;
    instr_t instr;
    word_t  imem_addr;
    daddr_t dmem_addr;
    word_t  dmem_wdata;
    word_t  dmem_rdata;
    logic   dmem_we;
    logic   dmem_re;

    word_t  rom [ROM_DEPTH];
    word_t  dmem [DMEM_DEPTH];
    word_t  preload [8];
    daddr_t exp_addr [MAX_STORES];   // Expected store sequence
    word_t  exp_data [MAX_STORES];
    int     n_instr;
    int     n_exp;
    word_t  loop_pc;

    core UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .instr      (instr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Synchronous instruction ROM
    always @(posedge clk) begin
        instr <= rom[imem_addr[7:2]];
    end

    // Combinational read, garbage unless dmem_re is high
    assign dmem_rdata = dmem_re ? dmem[dmem_addr] : 32'hBAD0_BAD0;

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr] <= dmem_wdata;
        end
    end

    function automatic word_t lfsr_step(input word_t s);
        word_t n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    function automatic word_t enc_r(input bit sub, input int rs2, input int rs1,
                                    input logic [2:0] f3, input int rd);
        return {1'b0, sub, 5'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], OP};
    endfunction

    function automatic word_t enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                    input int rd, input opcode_t opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic word_t enc_s(input int off, input int rs2, input int rs1);
        return {off[11:5], rs2[4:0], rs1[4:0], F3_LW_SW, off[4:0], STORE};
    endfunction

    // Offset bits land scattered in the B format
    function automatic word_t enc_b(input int off, input int rs2, input int rs1,
                                    input logic [2:0] f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], BRANCH};
    endfunction

    function automatic word_t enc_u(input int imm20, input int rd, input opcode_t opc);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    task automatic put(input word_t w);
        rom[n_instr] = w;
        n_instr++;
    endtask

    // Stores always use x0 as base
    task automatic put_store(input int rs2, input int off, input word_t data);
        exp_addr[n_exp] = daddr_t'(off / 4);
        exp_data[n_exp] = data;
        n_exp++;
        put(enc_s(off, rs2, 0));
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input daddr_t got, input daddr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_ctrl(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: %s is %b, expected %b",
                                $time, name, got, exp));
        end
    endtask

    task automatic wait_store();
        int n;
        n = 0;
        @(negedge clk);
        while (dmem_we !== 1'b1) begin
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("timeout while waiting for the next data memory store");
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_pc(input word_t target);
        int n;
        n = 0;
        while (imem_addr !== target) begin
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("timeout while waiting for the program to reach its final loop");
            end
            @(negedge clk);
        end
    endtask

    initial begin
        word_t lfsr;
        word_t auipc_pc;
        rst_n <= 1'b0;
        instr <= '0;
        lfsr = 32'd21421;
        for (int w = 0; w < 8; w++) begin
            for (int b = 0; b < 32; b++) begin
                lfsr = lfsr_step(lfsr);
                preload[w] = {preload[w][30:0], lfsr[0]};
            end
        end
        for (int a = 0; a < DMEM_DEPTH; a++) begin
            dmem[a] <= 32'hD00D_0000 | word_t'(a);
        end
        for (int w = 0; w < 8; w++) begin
            dmem[w] <= preload[w];
        end
        for (int a = 0; a < ROM_DEPTH; a++) begin
            rom[a] = '0;
        end
        n_instr = 0;
        n_exp   = 0;

        put(enc_u(32'h12345, 5, LUI));          // At RESET_PC
        put_store(5, 64, 32'h1234_5000);
        put(enc_i(0, 0, F3_LW_SW, 1, LOAD));
        put(enc_i(4, 0, F3_LW_SW, 2, LOAD));
        put(enc_r(1'b0, 2, 1, F3_ADD, 3));
        put_store(3, 68, preload[0] + preload[1]);
        put(enc_r(1'b1, 2, 1, F3_ADD, 3));
        put_store(3, 72, preload[0] - preload[1]);
        put(enc_r(1'b0, 2, 1, F3_AND, 3));
        put_store(3, 76, preload[0] & preload[1]);
        put(enc_r(1'b0, 2, 1, F3_OR, 3));
        put_store(3, 80, preload[0] | preload[1]);
        put(enc_r(1'b0, 2, 1, F3_XOR, 3));
        put_store(3, 84, preload[0] ^ preload[1]);
        put(enc_r(1'b0, 5, 1, F3_SLT, 3));      // Against the positive LUI value in x5
        put_store(3, 88, {31'b0, $signed(preload[0]) < $signed(32'h1234_5000)});
        put(enc_r(1'b0, 5, 1, F3_SLTU, 3));
        put_store(3, 92, {31'b0, preload[0] < 32'h1234_5000});
        put(enc_i(-5, 1, F3_ADD, 3, OP_IMM));
        put_store(3, 96, preload[0] + 32'hFFFF_FFFB);
        put(enc_i(12'h7F0, 1, F3_AND, 3, OP_IMM));
        put_store(3, 100, preload[0] & 32'h0000_07F0);
        put(enc_i(-256, 1, F3_OR, 3, OP_IMM));
        put_store(3, 104, preload[0] | 32'hFFFF_FF00);
        put(enc_i(12'h555, 1, F3_XOR, 3, OP_IMM));
        put_store(3, 108, preload[0] ^ 32'h0000_0555);
        put(enc_i(-1, 1, F3_SLT, 3, OP_IMM));
        put_store(3, 112, {31'b0, $signed(preload[0]) < -32'sd1});
        put(enc_i(-1, 1, F3_SLTU, 3, OP_IMM));
        put_store(3, 116, {31'b0, preload[0] < 32'hFFFF_FFFF});
        auipc_pc = word_t'(n_instr * 4);
        put(enc_u(32'h00001, 4, AUIPC));
        put_store(4, 120, auipc_pc + 32'h0000_1000);
        put(enc_b(8, 1, 1, F3_BEQ));            // Taken
        put(enc_s(124, 1, 0));                  // Must be skipped
        put(enc_b(8, 1, 1, F3_BNE));            // Falls through
        put_store(2, 128, preload[1]);
        put(enc_b(8, 0, 5, F3_BNE));            // Taken as x5 is nonzero
        put(enc_s(132, 1, 0));                  // Must be skipped
        put(enc_b(8, 0, 5, F3_BEQ));
        put_store(1, 136, preload[0]);
        put(enc_i(0, 5, F3_ADD, 0, OP_IMM));    // Write to x0
        put_store(0, 140, '0);
        put(enc_i(28, 0, F3_LW_SW, 6, LOAD));
        put_store(6, 144, preload[7]);
        loop_pc = word_t'(n_instr * 4);
        put(enc_b(0, 0, 0, F3_BEQ));            // Spin forever

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        for (int k = 0; k < n_exp; k++) begin
            wait_store();
            check_addr("dmem_addr", dmem_addr, exp_addr[k]);
            check_word("dmem_wdata", dmem_wdata, exp_data[k]);
            check_ctrl("dmem_re", dmem_re, 1'b0);
        end
        wait_pc(loop_pc);
        repeat (8) begin
            @(negedge clk);
            check_ctrl("dmem_we", dmem_we, 1'b0);
        end

        if (UUT.u_chk.fail_count != 0) begin
            abort_run($sformatf("%0d assertion failures in core_chk", UUT.u_chk.fail_count));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// File: verification/core_chk.sv
`timescale 1ns/1ps

module core_chk (
    input logic                  clk,
    input logic                  rst_n,
    input riscv_isa_pkg::word_t  imem_addr,
    input riscv_isa_pkg::instr_t instr,
    input core_ctrl_pkg::ctrl_t  ctrl,
    input logic                  dmem_we,
    input logic                  dmem_re
);
    import riscv_isa_pkg::*;

    int   fail_count = 0;
    logic known_op;

    assign known_op = instr.r.opcode inside {OP, OP_IMM, LOAD, STORE, BRANCH, LUI, AUIPC};

    // One data memory access per cycle
    we_re_excl: assert property (@(posedge clk) !(dmem_we && dmem_re))
        else begin
            fail_count++;
            $error("dmem_we and dmem_re are high together");
        end

    fetch_aligned: assert property (@(posedge clk) imem_addr[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("imem_addr is not word aligned");
        end

    no_store_in_reset: assert property (@(posedge clk) !rst_n |-> !dmem_we)
        else begin
            fail_count++;
            $error("dmem_we is high during reset");
        end

    // Unknown opcodes must leave the register file alone
    illegal_no_write: assert property (@(posedge clk) !known_op |-> !ctrl.reg_write)
        else begin
            fail_count++;
            $error("register write on an unrecognized opcode");
        end

endmodule

bind core core_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .instr     (instr),
    .ctrl      (ctrl),
    .dmem_we   (dmem_we),
    .dmem_re   (dmem_re)
);

// File: design/core.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module core (
    input  logic                    clk,
    input  logic                    rst_n,
    output riscv_isa_pkg::word_t    imem_addr,
    input  riscv_isa_pkg::instr_t   instr,     // Word at imem_addr of the last edge
    output logic [`DMEM_ADDR_W-1:0] dmem_addr,
    output riscv_isa_pkg::word_t    dmem_wdata,
    input  riscv_isa_pkg::word_t    dmem_rdata,
    output logic                    dmem_we,
    output logic                    dmem_re
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    ctrl_t    ctrl;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    reg_idx_t rd_idx;
    word_t    imm;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    op_a;
    word_t    op_b;
    word_t    alu_result;
    word_t    wb_data;
    word_t    pc;
    logic     alu_zero;

    decoder u_decoder (
        .instr (instr),
        .ctrl  (ctrl),
        .rs1   (rs1_idx),
        .rs2   (rs2_idx),
        .rd    (rd_idx),
        .imm   (imm)
    );

    register_file u_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (rs1_idx),
        .rs2    (rs2_idx),
        .rd     (rd_idx),
        .wdata  (wb_data),
        .we     (ctrl.reg_write),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    // Operand A is zero for LUI and PC for AUIPC
    always_comb begin
        case (ctrl.src_a)
            SRC_A_PC:   op_a = pc;
            SRC_A_ZERO: op_a = '0;
            default:    op_a = rs1_data;
        endcase
    end

    assign op_b = ctrl.alu_src_imm ? imm : rs2_data;

    alu u_alu (
        .a      (op_a),
        .b      (op_b),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    fetch_unit u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .branch       (ctrl.branch),
        .branch_on_ne (ctrl.branch_on_ne),
        .zero         (alu_zero),
        .imm          (imm),
        .pc           (pc),
        .fetch_addr   (imem_addr)
    );

    assign wb_data = ctrl.mem_to_reg ? dmem_rdata : alu_result;

    // Byte address to word address
    assign dmem_addr  = alu_result[`DMEM_ADDR_W+1:2];
    assign dmem_wdata = rs2_data;
    assign dmem_we    = ctrl.mem_write;
    assign dmem_re    = ctrl.mem_read;

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module fetch_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 branch,
    input  logic                 branch_on_ne,
    input  logic                 zero,
    input  riscv_isa_pkg::word_t imm,
    output riscv_isa_pkg::word_t pc,
    output riscv_isa_pkg::word_t fetch_addr
);
    import riscv_isa_pkg::*;

    word_t seq_pc;
    word_t target_pc;
    logic  take_branch;

    assign seq_pc    = pc + word_t'(`INSTR_STEP);
    assign target_pc = pc + imm;

    // BEQ wants zero, BNE wants nonzero
    assign take_branch = branch && (zero ^ branch_on_ne);

    // Held at the reset PC so the ROM has the first word ready on release
    assign fetch_addr = !rst_n      ? `RESET_PC :
                        take_branch ? target_pc : seq_pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else begin
            pc <= fetch_addr;
        end
    end

endmodule

// File: design/alu.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module alu (
    input  riscv_isa_pkg::word_t    a,
    input  riscv_isa_pkg::word_t    b,
    input  core_ctrl_pkg::alu_op_t  op,
    output riscv_isa_pkg::word_t    result,
    output logic                    zero
);
    import core_ctrl_pkg::*;

    logic lt_s;
    logic lt_u;

    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            SLT:     result = {{(`XLEN-1){1'b0}}, lt_s};
            SLTU:    result = {{(`XLEN-1){1'b0}}, lt_u};
            default: result = '0;
        endcase
    end

    // Equality test for branches after SUB
    assign zero = (result == '0);

endmodule

// File: design/register_file.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module register_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  riscv_isa_pkg::reg_idx_t rs1,
    input  riscv_isa_pkg::reg_idx_t rs2,
    input  riscv_isa_pkg::reg_idx_t rd,
    input  riscv_isa_pkg::word_t    wdata,
    input  logic                    we,
    output riscv_isa_pkg::word_t    rdata1,
    output riscv_isa_pkg::word_t    rdata2
);
    import riscv_isa_pkg::*;

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin // x0 stays zero
            regs[rd] <= wdata;
        end
    end

    // Asynchronous read ports
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

// File: design/decoder.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module decoder (
    input  riscv_isa_pkg::instr_t   instr,
    output core_ctrl_pkg::ctrl_t    ctrl,
    output riscv_isa_pkg::reg_idx_t rs1,
    output riscv_isa_pkg::reg_idx_t rs2,
    output riscv_isa_pkg::reg_idx_t rd,
    output riscv_isa_pkg::word_t    imm
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    alu_op_t alu_sel;
    logic    alu_legal;

    // Register fields sit at the same place in every format
    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;
    assign rd  = instr.r.rd;

    // Bit 30 selects SUB only for register-register ops
    always_comb begin
        alu_legal = 1'b1;
        case (instr.r.funct3)
            F3_ADD:  alu_sel = (instr.r.opcode == OP && instr.r.funct7[5]) ? SUB : ADD;
            F3_SLT:  alu_sel = SLT;
            F3_SLTU: alu_sel = SLTU;
            F3_XOR:  alu_sel = XOR;
            F3_OR:   alu_sel = OR;
            F3_AND:  alu_sel = AND;
            default: begin
                alu_sel   = ADD;  // Shifts are not supported
                alu_legal = 1'b0;
            end
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.src_a  = SRC_A_RS1;
        ctrl.alu_op = ADD;
        case (instr.r.opcode)
            OP: begin
                ctrl.reg_write = alu_legal;
                ctrl.alu_op    = alu_sel;
            end
            OP_IMM: begin
                ctrl.reg_write   = alu_legal;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_sel;
            end
            LOAD: begin
                ctrl.reg_write   = (instr.i.funct3 == F3_LW_SW);
                ctrl.mem_read    = (instr.i.funct3 == F3_LW_SW);
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            STORE: begin
                ctrl.mem_write   = (instr.s.funct3 == F3_LW_SW);
                ctrl.alu_src_imm = 1'b1;
            end
            BRANCH: begin
                ctrl.branch       = (instr.b.funct3 == F3_BEQ) || (instr.b.funct3 == F3_BNE);
                ctrl.branch_on_ne = (instr.b.funct3 == F3_BNE);
                ctrl.alu_op       = SUB; // Compare through the zero flag
            end
            LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.src_a       = SRC_A_ZERO;
            end
            AUIPC: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.src_a       = SRC_A_PC;
            end
            default: ; // Illegal opcode has no side effects
        endcase
    end

    always_comb begin
        case (instr.r.opcode)
            OP_IMM, LOAD: imm = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
            STORE:        imm = {{(`XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            BRANCH:       imm = {{(`XLEN-12){instr.b.imm_12}}, instr.b.imm_11,
                                 instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            LUI, AUIPC:   imm = {instr.u.imm, 12'h000};
            default:      imm = '0;
        endcase
    end

endmodule

// File: design/core_ctrl_pkg.sv
package core_ctrl_pkg;

    // ALU operation encodings
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b0001,
        AND  = 4'b0010,
        OR   = 4'b0011,
        XOR  = 4'b0100,
        SLTU = 4'b1001,
        SLT  = 4'b1010
    } alu_op_t;

    // Operand A source
    typedef enum logic [1:0] {
        SRC_A_PC   = 2'd0,
        SRC_A_ZERO = 2'd1,
        SRC_A_RS1  = 2'd2
    } src_a_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;   // Writeback from data memory
        logic    alu_src_imm;  // Operand B is the immediate
        logic    branch;
        logic    branch_on_ne; // BNE when set, BEQ otherwise
        src_a_t  src_a;
        alu_op_t alu_op;
    } ctrl_t;

endpackage

// File: design/riscv_isa_pkg.sv
`include "core_consts.svh"

package riscv_isa_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_fmt_t;

    // Branch offset bits are scattered over the word
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_idx_t    rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
    } instr_t;

    parameter logic [2:0] F3_ADD   = 3'b000; // Also SUB with bit 30
    parameter logic [2:0] F3_SLT   = 3'b010;
    parameter logic [2:0] F3_SLTU  = 3'b011;
    parameter logic [2:0] F3_XOR   = 3'b100;
    parameter logic [2:0] F3_OR    = 3'b110;
    parameter logic [2:0] F3_AND   = 3'b111;
    parameter logic [2:0] F3_LW_SW = 3'b010; // Word access only
    parameter logic [2:0] F3_BEQ   = 3'b000;
    parameter logic [2:0] F3_BNE   = 3'b001;

endpackage

// File: design/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath word width
`define XLEN 32

// Register file geometry
`define REG_ADDR_W 5
`define REG_COUNT 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Sequential PC increment in bytes
`define INSTR_STEP 4

// Data memory is addressed in words
`define DMEM_ADDR_W 10

`endif
